// ==== hw/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    typedef logic [7:0]  word_t;
    typedef logic [15:0] addr_t;

    typedef enum logic [2:0] {
        AM_IMPL,
        AM_IMM,
        AM_ZP,
        AM_ABS,
        AM_ZPX,
        AM_ABX
    } addr_mode_t;

    typedef enum logic [4:0] {
        I_NOP, I_LDA, I_LDX, I_STA, I_STX,
        I_ADC, I_SBC, I_AND, I_ORA, I_EOR,
        I_INX, I_INY, I_TAX,
        I_BEQ, I_BNE, I_BCS, I_BCC, I_BMI, I_BPL,
        I_JMP
    } instr_type_t;

    typedef enum logic [2:0] {
        ALU_PASS,
        ALU_ADC,
        ALU_SBC,
        ALU_AND,
        ALU_ORA,
        ALU_EOR,
        ALU_INC
    } alu_op_t;

    typedef enum logic [2:0] {
        DEST_NONE,
        DEST_A,
        DEST_X,
        DEST_Y,
        DEST_MEM
    } reg_dest_t;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        READ,
        EXECUTE,
        WRITEBACK
    } stage_t;

    // Every memory access is set address, wait, capture
    typedef enum logic [1:0] {
        SET_ADDR,
        WAIT,
        CAPTURE
    } mem_step_t;

    typedef struct packed {
        instr_type_t instr_type;
        alu_op_t     alu_op;
        addr_mode_t  addr_mode;
        reg_dest_t   reg_dest;
        logic [1:0]  instr_size;
        logic        use_alu;
        logic        mem_read;
        logic        mem_write;
    } decode_t;

    // Bit positions in P
    localparam int FLAG_C   = 0;
    localparam int FLAG_Z   = 1;
    localparam int FLAG_ONE = 5;
    localparam int FLAG_V   = 6;
    localparam int FLAG_N   = 7;

    // ------------------------------
    // 6502 opcode encodings
    // ------------------------------
    localparam word_t OP_LDA_IMM = 8'hA9, OP_LDA_ZP = 8'hA5, OP_LDA_ZPX = 8'hB5,
                      OP_LDA_ABS = 8'hAD, OP_LDA_ABX = 8'hBD;
    localparam word_t OP_LDX_IMM = 8'hA2, OP_LDX_ZP = 8'hA6, OP_LDX_ABS = 8'hAE;
    localparam word_t OP_STA_ZP  = 8'h85, OP_STA_ZPX = 8'h95,
                      OP_STA_ABS = 8'h8D, OP_STA_ABX = 8'h9D;
    localparam word_t OP_STX_ZP  = 8'h86, OP_STX_ABS = 8'h8E;
    localparam word_t OP_ADC_IMM = 8'h69, OP_ADC_ZP = 8'h65, OP_ADC_ZPX = 8'h75,
                      OP_ADC_ABS = 8'h6D, OP_ADC_ABX = 8'h7D;
    localparam word_t OP_SBC_IMM = 8'hE9, OP_SBC_ZP = 8'hE5, OP_SBC_ZPX = 8'hF5,
                      OP_SBC_ABS = 8'hED, OP_SBC_ABX = 8'hFD;
    localparam word_t OP_AND_IMM = 8'h29, OP_AND_ZP = 8'h25, OP_AND_ZPX = 8'h35,
                      OP_AND_ABS = 8'h2D, OP_AND_ABX = 8'h3D;
    localparam word_t OP_ORA_IMM = 8'h09, OP_ORA_ZP = 8'h05, OP_ORA_ZPX = 8'h15,
                      OP_ORA_ABS = 8'h0D, OP_ORA_ABX = 8'h1D;
    localparam word_t OP_EOR_IMM = 8'h49, OP_EOR_ZP = 8'h45, OP_EOR_ZPX = 8'h55,
                      OP_EOR_ABS = 8'h4D, OP_EOR_ABX = 8'h5D;
    localparam word_t OP_INX = 8'hE8, OP_INY = 8'hC8, OP_TAX = 8'hAA;
    localparam word_t OP_BEQ = 8'hF0, OP_BNE = 8'hD0, OP_BCS = 8'hB0,
                      OP_BCC = 8'h90, OP_BMI = 8'h30, OP_BPL = 8'h10;
    localparam word_t OP_JMP_ABS = 8'h4C;

endpackage

`default_nettype wire

// ==== hw/reg_file_if.sv ====
`default_nettype none

interface reg_file_if import cpu_pkg::*; ();
    logic  we_a;
    logic  we_x;
    logic  we_y;
    logic  we_pc;
    logic  we_p;
    word_t data_in;
    addr_t pc_in;
    word_t p_in;

    word_t a;
    word_t x;
    word_t y;
    addr_t pc;
    word_t p;

    modport sequencer (
        output we_a, we_x, we_y, we_pc, we_p, data_in, pc_in, p_in,
        input  a, x, y, pc, p
    );

    modport regs (
        input  we_a, we_x, we_y, we_pc, we_p, data_in, pc_in, p_in,
        output a, x, y, pc, p
    );
endinterface

`default_nettype wire

// ==== hw/opcode_decoder.sv ====
`default_nettype none

module opcode_decoder import cpu_pkg::*; (
    input  wire word_t opcode,
    output decode_t    dec
);
    instr_type_t itype;
    addr_mode_t  mode;
    reg_dest_t   dest;

    // Anything outside the table is a NOP
    always_comb begin
        case (opcode)
            OP_LDA_IMM, OP_LDA_ZP, OP_LDA_ZPX, OP_LDA_ABS, OP_LDA_ABX:
                itype = I_LDA;
            OP_LDX_IMM, OP_LDX_ZP, OP_LDX_ABS:
                itype = I_LDX;
            OP_STA_ZP, OP_STA_ZPX, OP_STA_ABS, OP_STA_ABX:
                itype = I_STA;
            OP_STX_ZP, OP_STX_ABS:
                itype = I_STX;
            OP_ADC_IMM, OP_ADC_ZP, OP_ADC_ZPX, OP_ADC_ABS, OP_ADC_ABX:
                itype = I_ADC;
            OP_SBC_IMM, OP_SBC_ZP, OP_SBC_ZPX, OP_SBC_ABS, OP_SBC_ABX:
                itype = I_SBC;
            OP_AND_IMM, OP_AND_ZP, OP_AND_ZPX, OP_AND_ABS, OP_AND_ABX:
                itype = I_AND;
            OP_ORA_IMM, OP_ORA_ZP, OP_ORA_ZPX, OP_ORA_ABS, OP_ORA_ABX:
                itype = I_ORA;
            OP_EOR_IMM, OP_EOR_ZP, OP_EOR_ZPX, OP_EOR_ABS, OP_EOR_ABX:
                itype = I_EOR;
            OP_INX:     itype = I_INX;
            OP_INY:     itype = I_INY;
            OP_TAX:     itype = I_TAX;
            OP_BEQ:     itype = I_BEQ;
            OP_BNE:     itype = I_BNE;
            OP_BCS:     itype = I_BCS;
            OP_BCC:     itype = I_BCC;
            OP_BMI:     itype = I_BMI;
            OP_BPL:     itype = I_BPL;
            OP_JMP_ABS: itype = I_JMP;
            default:    itype = I_NOP;
        endcase
    end

    // Mode comes from the bbb field and JMP lands on ABS by itself
    always_comb begin
        case (opcode[4:2])
            3'b000, 3'b010: mode = AM_IMM;
            3'b001:         mode = AM_ZP;
            3'b011:         mode = AM_ABS;
            3'b101:         mode = AM_ZPX;
            3'b111:         mode = AM_ABX;
            default:        mode = AM_IMPL;
        endcase
        if (itype inside {I_NOP, I_INX, I_INY, I_TAX})
            mode = AM_IMPL;
        else if (itype inside {I_BEQ, I_BNE, I_BCS, I_BCC, I_BMI, I_BPL})
            mode = AM_IMM;
    end

    always_comb begin
        case (itype)
            I_LDA, I_ADC, I_SBC, I_AND, I_ORA, I_EOR: dest = DEST_A;
            I_LDX, I_INX, I_TAX:                      dest = DEST_X;
            I_INY:                                    dest = DEST_Y;
            I_STA, I_STX:                             dest = DEST_MEM;
            default:                                  dest = DEST_NONE;
        endcase
    end

    always_comb begin
        dec.instr_type = itype;
        dec.addr_mode  = mode;
        dec.reg_dest   = dest;
        case (itype)
            I_ADC:        dec.alu_op = ALU_ADC;
            I_SBC:        dec.alu_op = ALU_SBC;
            I_AND:        dec.alu_op = ALU_AND;
            I_ORA:        dec.alu_op = ALU_ORA;
            I_EOR:        dec.alu_op = ALU_EOR;
            I_INX, I_INY: dec.alu_op = ALU_INC;
            default:      dec.alu_op = ALU_PASS;
        endcase
        case (mode)
            AM_IMPL:        dec.instr_size = 2'd1;
            AM_ABS, AM_ABX: dec.instr_size = 2'd3;
            default:        dec.instr_size = 2'd2;
        endcase
        dec.use_alu   = dest inside {DEST_A, DEST_X, DEST_Y};
        dec.mem_read  = dec.use_alu && (mode inside {AM_ZP, AM_ZPX, AM_ABS, AM_ABX});
        dec.mem_write = (dest == DEST_MEM);
    end

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`default_nettype none

module alu import cpu_pkg::*; (
    input  wire alu_op_t op,
    input  wire word_t   a,
    input  wire word_t   b,
    input  wire logic    cin,
    output word_t        result,
    output logic [3:0]   flags
);
    word_t      b_eff;
    logic [8:0] sum;
    logic       carry;
    logic       ovf;

    // SBC is A + ~B + C
    assign b_eff = (op == ALU_SBC) ? ~b : b;
    assign sum   = {1'b0, a} + {1'b0, b_eff} + {8'h00, cin};

    always_comb begin
        carry = 1'b0;
        ovf   = 1'b0;
        case (op)
            ALU_ADC, ALU_SBC: begin
                result = sum[7:0];
                carry  = sum[8];
                ovf    = (a[7] == b_eff[7]) && (sum[7] != a[7]);
            end
            ALU_AND: result = a & b;
            ALU_ORA: result = a | b;
            ALU_EOR: result = a ^ b;
            ALU_INC: result = a + 8'd1;
            default: result = b;
        endcase
    end

    // Packed as N V Z C
    assign flags = {result[7], ovf, result == 8'h00, carry};

    op_known: assert final (op inside {ALU_PASS, ALU_ADC, ALU_SBC, ALU_AND,
                                       ALU_ORA, ALU_EOR, ALU_INC})
        else $error("alu: unknown op %0d", op);

endmodule

`default_nettype wire

// ==== hw/register_file.sv ====
`default_nettype none

module register_file import cpu_pkg::*; #(
    parameter addr_t RESET_PC = 16'h1000,
    parameter word_t RESET_P  = 8'h20
) (
    input  wire logic clk,
    input  wire logic reset,
    reg_file_if.regs  regs
);

    always_ff @(posedge clk) begin
        if (reset) begin
            regs.a  <= 8'h00;
            regs.x  <= 8'h00;
            regs.y  <= 8'h00;
            regs.pc <= RESET_PC;
            regs.p  <= RESET_P;
        end else begin
            if (regs.we_a) begin
                regs.a <= regs.data_in;
            end
            if (regs.we_x) begin
                regs.x <= regs.data_in;
            end
            if (regs.we_y) begin
                regs.y <= regs.data_in;
            end
            if (regs.we_pc) begin
                regs.pc <= regs.pc_in;
            end
            if (regs.we_p) begin
                regs.p <= regs.p_in;
            end
        end
    end

    // Flag merge in the sequencer must keep the constant bit
    p_bit5_set: assert property (@(posedge clk) disable iff (reset) regs.p[FLAG_ONE])
        else $error("register_file: P bit 5 cleared");

endmodule

`default_nettype wire

// ==== hw/cpu_sequencer.sv ====
`default_nettype none

module cpu_sequencer import cpu_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire word_t      mem_rdata,
    input  wire decode_t    dec,
    input  wire word_t      alu_result,
    input  wire logic [3:0] alu_flags,
    output word_t           opcode,
    output alu_op_t         alu_op,
    output word_t           alu_a,
    output word_t           alu_b,
    output logic            alu_cin,
    output addr_t           mem_addr,
    output word_t           mem_wdata,
    output logic            mem_rd,
    output logic            mem_wr,
    output logic            sync,
    reg_file_if.sequencer   regs
);
    stage_t     stage;
    stage_t     next_stage;
    mem_step_t  step;
    mem_step_t  next_step;
    logic [1:0] count;
    logic [1:0] count_inc;
    logic [1:0] op_bytes;
    logic       operand_phase;

    word_t      operand_lo;
    word_t      operand_hi;
    word_t      operand_val;
    word_t      result_q;
    logic [3:0] flags_q;

    word_t      zpx_lo;
    addr_t      eff_addr;
    addr_t      pc_seq;
    addr_t      next_pc;
    logic       taken;
    logic       wb;

    assign op_bytes      = dec.instr_size - 2'd1;
    assign count_inc     = count + 2'd1;
    assign operand_phase = (count < op_bytes);
    assign wb            = (stage == WRITEBACK);

    // ------------------------------
    // Stage machine
    // ------------------------------
    always_comb begin
        next_stage = stage;
        next_step  = step;
        case (stage)
            FETCH, READ: begin
                case (step)
                    SET_ADDR: next_step = WAIT;
                    WAIT:     next_step = CAPTURE;
                    default: begin
                        next_step = SET_ADDR;
                        if (stage == FETCH)
                            next_stage = DECODE;
                        else if (!(count_inc < op_bytes) &&
                                 !(dec.mem_read && count_inc == op_bytes))
                            next_stage = EXECUTE;
                    end
                endcase
            end
            DECODE:    next_stage = (dec.instr_size == 2'd1) ? EXECUTE : READ;
            EXECUTE:   next_stage = WRITEBACK;
            default:   next_stage = FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage  <= FETCH;
            step   <= SET_ADDR;
            count  <= 2'd0;
            opcode <= 8'h00;
        end else begin
            stage <= next_stage;
            step  <= next_step;
            if (stage == FETCH && step == CAPTURE)
                opcode <= mem_rdata;
            if (stage == DECODE)
                count <= 2'd0;
            else if (stage == READ && step == CAPTURE)
                count <= count_inc;
        end
    end

    // Operand bytes, then the data byte if the mode reads memory
    always_ff @(posedge clk) begin
        if (stage == READ && step == CAPTURE) begin
            if (!operand_phase)
                operand_val <= mem_rdata;
            else if (count == 2'd0)
                operand_lo <= mem_rdata;
            else
                operand_hi <= mem_rdata;
        end
        if (stage == EXECUTE) begin
            result_q <= alu_result;
            flags_q  <= alu_flags;
        end
    end

    // ------------------------------
    // Addresses and memory strobes
    // ------------------------------
    assign zpx_lo = operand_lo + regs.x;

    always_comb begin
        case (dec.addr_mode)
            AM_ZP:   eff_addr = {8'h00, operand_lo};
            AM_ZPX:  eff_addr = {8'h00, zpx_lo};
            AM_ABX:  eff_addr = {operand_hi, operand_lo} + {8'h00, regs.x};
            default: eff_addr = {operand_hi, operand_lo};
        endcase
    end

    assign mem_addr = (stage == FETCH) ? regs.pc :
                      operand_phase    ? regs.pc + {14'd0, count} + 16'd1 :
                                         eff_addr;
    assign mem_rd    = !reset && (stage == FETCH || stage == READ) && step != CAPTURE;
    assign mem_wr    = wb && dec.mem_write;
    assign mem_wdata = (dec.instr_type == I_STX) ? regs.x : regs.a;
    assign sync      = !reset && stage == FETCH;

    // ------------------------------
    // ALU operands
    // ------------------------------
    assign alu_op  = dec.alu_op;
    assign alu_cin = regs.p[FLAG_C];

    always_comb begin
        case (dec.reg_dest)
            DEST_X:  alu_a = regs.x;
            DEST_Y:  alu_a = regs.y;
            default: alu_a = regs.a;
        endcase
        if (dec.instr_type == I_TAX)
            alu_b = regs.a;
        else if (dec.addr_mode == AM_IMM)
            alu_b = operand_lo;
        else
            alu_b = operand_val;
    end

    // ------------------------------
    // Writeback
    // ------------------------------
    always_comb begin
        case (dec.instr_type)
            I_BEQ:   taken = regs.p[FLAG_Z];
            I_BNE:   taken = !regs.p[FLAG_Z];
            I_BCS:   taken = regs.p[FLAG_C];
            I_BCC:   taken = !regs.p[FLAG_C];
            I_BMI:   taken = regs.p[FLAG_N];
            I_BPL:   taken = !regs.p[FLAG_N];
            default: taken = 1'b0;
        endcase
    end

    assign pc_seq  = regs.pc + {14'd0, dec.instr_size};
    assign next_pc = (dec.instr_type == I_JMP) ? {operand_hi, operand_lo} :
                     taken ? pc_seq + {{8{operand_lo[7]}}, operand_lo} : pc_seq;

    assign regs.we_a    = wb && dec.use_alu && dec.reg_dest == DEST_A;
    assign regs.we_x    = wb && dec.use_alu && dec.reg_dest == DEST_X;
    assign regs.we_y    = wb && dec.use_alu && dec.reg_dest == DEST_Y;
    assign regs.we_p    = wb && dec.use_alu;
    assign regs.we_pc   = wb;
    assign regs.data_in = result_q;
    assign regs.pc_in   = next_pc;

    // Z and N always, C and V only from add and subtract
    always_comb begin
        regs.p_in         = regs.p;
        regs.p_in[FLAG_Z] = flags_q[1];
        regs.p_in[FLAG_N] = flags_q[3];
        if (dec.alu_op == ALU_ADC || dec.alu_op == ALU_SBC) begin
            regs.p_in[FLAG_C] = flags_q[0];
            regs.p_in[FLAG_V] = flags_q[2];
        end
        regs.p_in[FLAG_ONE] = 1'b1;
    end

    rd_wr_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(mem_rd && mem_wr))
        else $error("cpu_sequencer: read and write strobes together");

    // A store sits between execute and the next fetch
    wr_in_writeback: assert property (@(posedge clk) disable iff (reset)
        mem_wr |-> $past(stage == EXECUTE) ##1 sync)
        else $error("cpu_sequencer: write outside writeback");

endmodule

`default_nettype wire

// ==== hw/cpu_top.sv ====
`default_nettype none

module cpu_top import cpu_pkg::*; #(
    parameter addr_t RESET_PC = 16'h1000,
    parameter word_t RESET_P  = 8'h20
) (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire word_t mem_rdata,
    output addr_t      mem_addr,
    output word_t      mem_wdata,
    output logic       mem_rd,
    output logic       mem_wr,
    output logic       sync,
    output word_t      a,
    output word_t      x,
    output word_t      y,
    output addr_t      pc,
    output word_t      p
);
    word_t      opcode;
    decode_t    dec;
    alu_op_t    alu_op;
    word_t      alu_a;
    word_t      alu_b;
    logic       alu_cin;
    word_t      alu_result;
    logic [3:0] alu_flags;

    reg_file_if rf ();

    cpu_sequencer u_sequencer (
        .clk        (clk),
        .reset      (reset),
        .mem_rdata  (mem_rdata),
        .dec        (dec),
        .alu_result (alu_result),
        .alu_flags  (alu_flags),
        .opcode     (opcode),
        .alu_op     (alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_cin    (alu_cin),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rd     (mem_rd),
        .mem_wr     (mem_wr),
        .sync       (sync),
        .regs       (rf.sequencer)
    );

    opcode_decoder u_decoder (
        .opcode (opcode),
        .dec    (dec)
    );

    alu u_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .cin    (alu_cin),
        .result (alu_result),
        .flags  (alu_flags)
    );

    register_file #(
        .RESET_PC (RESET_PC),
        .RESET_P  (RESET_P)
    ) u_regs (
        .clk   (clk),
        .reset (reset),
        .regs  (rf.regs)
    );

    assign a  = rf.a;
    assign x  = rf.x;
    assign y  = rf.y;
    assign pc = rf.pc;
    assign p  = rf.p;

endmodule

`default_nettype wire

// ==== sim/cpu_model.svh ====
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// Reference memory and architectural state
word_t       ref_mem [0:65535];
instr_type_t kind_of [0:255];
addr_mode_t  mode_of [0:255];
word_t       kept_ops [$];
word_t       m_a;
word_t       m_x;
word_t       m_y;
word_t       m_p;
addr_t       m_pc;
addr_t       exp_st_addr [$];
word_t       exp_st_data [$];
logic [31:0] rng;

function automatic logic [31:0] next_random();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
endfunction

function automatic int size_of(input addr_mode_t mode);
    case (mode)
        AM_IMPL:        return 1;
        AM_ABS, AM_ABX: return 3;
        default:        return 2;
    endcase
endfunction

function automatic logic is_branch(input instr_type_t kind);
    return kind inside {I_BEQ, I_BNE, I_BCS, I_BCC, I_BMI, I_BPL};
endfunction

task automatic add_op(input word_t op, input instr_type_t kind, input addr_mode_t mode);
    kind_of[op] = kind;
    mode_of[op] = mode;
    kept_ops.push_back(op);
endtask

// Zero marks a mode the instruction does not have
task automatic add_group(input instr_type_t kind, input word_t imm, input word_t zp,
                         input word_t zpx, input word_t abs_op, input word_t abx);
    if (imm != 8'h00)
        add_op(imm, kind, AM_IMM);
    if (zp != 8'h00)
        add_op(zp, kind, AM_ZP);
    if (zpx != 8'h00)
        add_op(zpx, kind, AM_ZPX);
    if (abs_op != 8'h00)
        add_op(abs_op, kind, AM_ABS);
    if (abx != 8'h00)
        add_op(abx, kind, AM_ABX);
endtask

task automatic build_table();
    for (int i = 0; i < 256; i++) begin
        kind_of[i] = I_NOP;
        mode_of[i] = AM_IMPL;
    end
    add_group(I_LDA, OP_LDA_IMM, OP_LDA_ZP, OP_LDA_ZPX, OP_LDA_ABS, OP_LDA_ABX);
    add_group(I_LDX, OP_LDX_IMM, OP_LDX_ZP, 8'h00, OP_LDX_ABS, 8'h00);
    add_group(I_STA, 8'h00, OP_STA_ZP, OP_STA_ZPX, OP_STA_ABS, OP_STA_ABX);
    add_group(I_STX, 8'h00, OP_STX_ZP, 8'h00, OP_STX_ABS, 8'h00);
    add_group(I_ADC, OP_ADC_IMM, OP_ADC_ZP, OP_ADC_ZPX, OP_ADC_ABS, OP_ADC_ABX);
    add_group(I_SBC, OP_SBC_IMM, OP_SBC_ZP, OP_SBC_ZPX, OP_SBC_ABS, OP_SBC_ABX);
    add_group(I_AND, OP_AND_IMM, OP_AND_ZP, OP_AND_ZPX, OP_AND_ABS, OP_AND_ABX);
    add_group(I_ORA, OP_ORA_IMM, OP_ORA_ZP, OP_ORA_ZPX, OP_ORA_ABS, OP_ORA_ABX);
    add_group(I_EOR, OP_EOR_IMM, OP_EOR_ZP, OP_EOR_ZPX, OP_EOR_ABS, OP_EOR_ABX);
    add_op(OP_INX, I_INX, AM_IMPL);
    add_op(OP_INY, I_INY, AM_IMPL);
    add_op(OP_TAX, I_TAX, AM_IMPL);
    add_op(OP_BEQ, I_BEQ, AM_IMM);
    add_op(OP_BNE, I_BNE, AM_IMM);
    add_op(OP_BCS, I_BCS, AM_IMM);
    add_op(OP_BCC, I_BCC, AM_IMM);
    add_op(OP_BMI, I_BMI, AM_IMM);
    add_op(OP_BPL, I_BPL, AM_IMM);
    add_op(OP_JMP_ABS, I_JMP, AM_ABS);
endtask

// ------------------------------
// Random program
// ------------------------------
task automatic build_program(input int count, output addr_t halt, output int slots);
    addr_t here;
    addr_t target;
    word_t op;
    int    pad;
    here  = RESET_PC;
    slots = 0;
    for (int i = 0; i < count; i++) begin
        op = kept_ops[next_random() % kept_ops.size()];
        // Roughly one in eight is an undefined opcode
        if (next_random() % 8 == 0) begin
            op = word_t'(next_random());
            if (kind_of[op] != I_NOP)
                op = 8'hEA;
        end
        ref_mem[here] = op;
        ref_mem[here + 16'd1] = word_t'(next_random());
        ref_mem[here + 16'd2] = 8'h20;
        pad = 0;
        if (is_branch(kind_of[op])) begin
            pad = next_random() % 7;
            ref_mem[here + 16'd1] = word_t'(pad);
        end else if (kind_of[op] == I_JMP) begin
            pad    = next_random() % 7;
            target = here + 16'd3 + addr_t'(pad);
            ref_mem[here + 16'd1] = target[7:0];
            ref_mem[here + 16'd2] = target[15:8];
        end
        here = here + addr_t'(size_of(mode_of[op]));
        for (int k = 0; k < pad; k++) begin
            ref_mem[here] = 8'hEA;
            here = here + 16'd1;
        end
        slots = slots + 1 + pad;
    end
    // Jump to itself ends the program
    halt = here;
    ref_mem[here] = OP_JMP_ABS;
    ref_mem[here + 16'd1] = here[7:0];
    ref_mem[here + 16'd2] = here[15:8];
endtask

// ------------------------------
// Instruction-level model
// ------------------------------
task automatic set_zn(input word_t v);
    m_p[FLAG_Z] = (v == 8'h00);
    m_p[FLAG_N] = v[7];
endtask

task automatic add_with_carry(input word_t b);
    logic [8:0] sum;
    sum = {1'b0, m_a} + {1'b0, b} + {8'h00, m_p[FLAG_C]};
    m_p[FLAG_V] = (m_a[7] == b[7]) && (sum[7] != m_a[7]);
    m_p[FLAG_C] = sum[8];
    m_a = sum[7:0];
    set_zn(m_a);
endtask

task automatic model_step(output int cycles);
    word_t       op;
    word_t       lo;
    word_t       hi;
    word_t       operand;
    instr_type_t kind;
    addr_mode_t  mode;
    addr_t       ea;
    addr_t       next_pc;
    logic        taken;
    logic        reads;
    op   = ref_mem[m_pc];
    kind = kind_of[op];
    mode = mode_of[op];
    lo   = ref_mem[m_pc + 16'd1];
    hi   = ref_mem[m_pc + 16'd2];
    case (mode)
        AM_ZP:   ea = {8'h00, lo};
        AM_ZPX:  ea = {8'h00, word_t'(lo + m_x)};
        AM_ABX:  ea = {hi, lo} + {8'h00, m_x};
        default: ea = {hi, lo};
    endcase
    operand = (mode == AM_IMM) ? lo : ref_mem[ea];
    next_pc = m_pc + addr_t'(size_of(mode));
    taken   = 1'b0;
    case (kind)
        I_LDA: begin
            m_a = operand;
            set_zn(m_a);
        end
        I_LDX: begin
            m_x = operand;
            set_zn(m_x);
        end
        I_STA, I_STX: begin
            ref_mem[ea] = (kind == I_STA) ? m_a : m_x;
            exp_st_addr.push_back(ea);
            exp_st_data.push_back(ref_mem[ea]);
        end
        I_ADC: add_with_carry(operand);
        I_SBC: add_with_carry(~operand);
        I_AND: begin
            m_a = m_a & operand;
            set_zn(m_a);
        end
        I_ORA: begin
            m_a = m_a | operand;
            set_zn(m_a);
        end
        I_EOR: begin
            m_a = m_a ^ operand;
            set_zn(m_a);
        end
        I_INX: begin
            m_x = m_x + 8'd1;
            set_zn(m_x);
        end
        I_INY: begin
            m_y = m_y + 8'd1;
            set_zn(m_y);
        end
        I_TAX: begin
            m_x = m_a;
            set_zn(m_x);
        end
        I_BEQ: taken = m_p[FLAG_Z];
        I_BNE: taken = !m_p[FLAG_Z];
        I_BCS: taken = m_p[FLAG_C];
        I_BCC: taken = !m_p[FLAG_C];
        I_BMI: taken = m_p[FLAG_N];
        I_BPL: taken = !m_p[FLAG_N];
        I_JMP: next_pc = {hi, lo};
        default: ;
    endcase
    if (taken)
        next_pc = next_pc + {{8{lo[7]}}, lo};
    m_pc = next_pc;
    // Fetch, decode, three per operand byte, data read, execute, writeback
    reads = (kind inside {I_LDA, I_LDX, I_ADC, I_SBC, I_AND, I_ORA, I_EOR}) &&
            (mode inside {AM_ZP, AM_ZPX, AM_ABS, AM_ABX});
    cycles = 3 + 1 + 3 * (size_of(mode) - 1) + (reads ? 3 : 0) + 2;
endtask

`endif

// ==== sim/cpu_tb.sv ====
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

    localparam addr_t RESET_PC  = 16'h1000;
    localparam word_t RESET_P   = 8'h20;
    localparam int    NUM_INSTR = 200;

    logic  clk;
    logic  reset;
    word_t mem_rdata;
    addr_t mem_addr;
    word_t mem_wdata;
    logic  mem_rd;
    logic  mem_wr;
    logic  sync;
    word_t a;
    word_t x;
    word_t y;
    addr_t pc;
    word_t p;

    word_t mem [0:65535];
    logic  rd_pending = 1'b0;
    addr_t rd_addr;

    int    errors = 0;
    int    checks = 0;
    int    cycle_count = 0;
    int    cycle_limit = 1000000;
    int    since_sync = 0;
    int    exp_cycles = 0;
    int    halt_hits = 0;
    int    slots;
    logic  sync_q = 1'b0;
    logic  started = 1'b0;
    logic  done = 1'b0;
    addr_t halt_addr;

    `include "cpu_model.svh"

    cpu_top #(
        .RESET_PC (RESET_PC),
        .RESET_P  (RESET_P)
    ) dut (
        .clk       (clk),
        .reset     (reset),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .sync      (sync),
        .a         (a),
        .x         (x),
        .y         (y),
        .pc        (pc),
        .p         (p)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_store(input addr_t got_addr, input word_t got_data,
                               input addr_t exp_addr, input word_t exp_data);
        checks++;
        if (got_addr !== exp_addr || got_data !== exp_data) begin
            errors++;
            $display("CHECK FAILED mem_addr/mem_wdata: got %h/%h, expected %h/%h",
                     got_addr, got_data, exp_addr, exp_data);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_write();
        if (exp_st_addr.size() == 0) begin
            errors++;
            $display("Unexpected memory write to %h at pc %h", mem_addr, pc);
        end else begin
            check_store(mem_addr, mem_wdata, exp_st_addr.pop_front(), exp_st_data.pop_front());
        end
    endtask

    // Registers are compared at each instruction boundary
    task automatic check_boundary();
        if (!started) begin
            check_addr("mem_addr", mem_addr, RESET_PC);
            started = 1'b1;
        end else begin
            check_count("cycles", since_sync, exp_cycles);
        end
        check_word("a", a, m_a);
        check_word("x", x, m_x);
        check_word("y", y, m_y);
        check_word("p", p, m_p);
        check_addr("pc", pc, m_pc);
        since_sync = 0;
        if (m_pc == halt_addr)
            halt_hits++;
        if (halt_hits == 2)
            done = 1'b1;
        else
            model_step(exp_cycles);
    endtask

    // Memory answers a read one cycle after the request
    always @(negedge clk) begin
        if (rd_pending)
            mem_rdata <= mem[rd_addr];
        rd_pending <= (mem_rd === 1'b1);
        rd_addr    <= mem_addr;
        if (mem_wr === 1'b1)
            mem[mem_addr] <= mem_wdata;
    end

    always @(posedge clk) begin
        if (reset) begin
            if (mem_rd !== 1'b0 || mem_wr !== 1'b0 || sync !== 1'b0) begin
                errors++;
                $display("Memory strobe or sync active during reset");
            end
        end else if (!done) begin
            since_sync++;
            if (mem_wr === 1'b1)
                check_write();
            if (sync === 1'b1 && !sync_q)
                check_boundary();
        end
        sync_q = (sync === 1'b1);
    end

    always @(negedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, final JMP never reached", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        reset     = 1'b1;
        mem_rdata = 8'h00;
        rng       = 32'd96051;
        build_table();
        for (int i = 0; i < 65536; i++)
            ref_mem[i] = word_t'(i[15:8] ^ i[7:0] ^ 8'h5A);
        // Random data in zero page and page 0x20
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = word_t'(next_random());
            ref_mem[16'h2000 + i] = word_t'(next_random());
        end
        build_program(NUM_INSTR, halt_addr, slots);
        for (int i = 0; i < 65536; i++)
            mem[i] = ref_mem[i];
        m_a  = 8'h00;
        m_x  = 8'h00;
        m_y  = 8'h00;
        m_p  = RESET_P;
        m_pc = RESET_PC;
        // Slowest instruction is 15 cycles
        cycle_limit = (slots + 4) * 15 + 50;

        repeat (2) @(negedge clk);
        reset <= 1'b0;
        wait (done);

        if (exp_st_addr.size() != 0) begin
            errors++;
            $display("%0d expected stores never reached memory", exp_st_addr.size());
        end
        $display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycle_count);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cpu_top.f ====
+incdir+sim
hw/cpu_pkg.sv
hw/reg_file_if.sv
hw/opcode_decoder.sv
hw/alu.sv
hw/register_file.sv
hw/cpu_sequencer.sv
hw/cpu_top.sv
sim/cpu_tb.sv
